// ==== Makefile ====
# Verilator build and run of the I/O port block testbench

TOP = tb_zx_io

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

// ==== flist.f ====
+incdir+hw
hw/zx_io_pkg.sv
hw/io_cycle_decode.sv
hw/paging_regs.sv
hw/machine_cfg_regs.sv
hw/port_read_mux.sv
hw/zx_io_top.sv
verif/tb_zx_io.sv

// ==== hw/io_cycle_decode.sv ====
/* bus cycle edge detect, port decode, write pulse
   generation, porthit and data bus output enable */

`timescale 1ns/1ns
`include "zx_io_settings.svh"

module io_cycle_decode
(
	input  logic                  fclk,
	input  logic                  rst_n,
	input  logic [15:0]           a,
	input  logic [7:0]            din,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  shadow,     // from BF config or dos
	output zx_io_pkg::bus_wr_s    bus_wr,
	output zx_io_pkg::port_sel_s  rd_sel,
	output logic                  porthit,
	output logic                  dataout_en
);

	logic [7:0] loa;
	zx_io_pkg::port_sel_s dec_sel; // live decode of the current address
	logic iowr_now;                // write strobe as seen this edge
	logic iowr_q;                  // previous sample
	logic wr_start;
	logic wr_pulse;
	zx_io_pkg::port_sel_s wr_sel;
	logic [7:0] wr_ahi;
	logic [7:0] wr_din;
	logic wr_a3;

	assign loa = a[7:0];

	////////////////////////////////////////////////////////////
	// port decode
	////////////////////////////////////////////////////////////

	always_comb
	begin
		dec_sel = '0;
		dec_sel.fe_group = (loa == `ZX_PORT_FE) || (loa == `ZX_PORT_F6) || (loa == `ZX_PORT_FC);
		dec_sel.fe_only  = (loa == `ZX_PORT_FE);
		dec_sel.p7ffd    = ((loa == `ZX_PORT_FD) || (loa == `ZX_PORT_FC)) && !a[15];
		// EFF7 lives at a8=1 normally, a8=0 in shadow mode
		dec_sel.peff7    = (loa == `ZX_PORT_F7) && !a[12] && (a[8] != shadow);
		dec_sel.bf       = (loa == `ZX_PORT_BF);
		dec_sel.be       = (loa == `ZX_PORT_BE);
		dec_sel.bd       = (loa == `ZX_PORT_BD);
		dec_sel.ulaplus  = (loa == `ZX_PORT_ULAPLUS);
	end

	assign rd_sel     = dec_sel;
	assign porthit    = |dec_sel;
	assign dataout_en = porthit && !iorq_n && !rd_n; // drive cpu bus on our own reads

	////////////////////////////////////////////////////////////
	// write edge detect
	////////////////////////////////////////////////////////////

	assign iowr_now = !(iorq_n || wr_n);
	assign wr_start = iowr_now && !iowr_q; // first active sample only

	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
		begin
			iowr_q   <= 1'b0;
			wr_pulse <= 1'b0;
		end
		else
		begin
			iowr_q   <= iowr_now;
			wr_pulse <= wr_start;
		end

	// address and data frozen with the pulse
	always_ff @(posedge fclk)
		if (wr_start)
		begin
			wr_sel       <= dec_sel;
			wr_sel.peff7 <= dec_sel.peff7 && !shadow; // shadow EFF7 is read-only
			wr_ahi       <= a[15:8];
			wr_a3        <= a[3];
			wr_din       <= din;
		end

	assign bus_wr = '{wr: wr_pulse, sel: wr_sel, ahi: wr_ahi, a3: wr_a3, din: wr_din};

	// FC may alias 7FFD, otherwise a write hits one register group
	a_one_port_per_write: assert property (@(posedge fclk) disable iff (!rst_n)
		bus_wr.wr |-> $onehot0({bus_wr.sel.fe_group || bus_wr.sel.p7ffd, bus_wr.sel.peff7,
			bus_wr.sel.bf, bus_wr.sel.be, bus_wr.sel.bd, bus_wr.sel.ulaplus}));

endmodule

// ==== hw/machine_cfg_regs.sv ====
/* border and beeper, BF config, BE nmi clear,
   BD break address and fdd mask, ULAplus registers */

`timescale 1ns/1ns
`include "zx_io_settings.svh"

module machine_cfg_regs
(
	input  logic               fclk,
	input  logic               rst_n,
	input  zx_io_pkg::bus_wr_s bus_wr,
	input  logic               dos,
	output logic               shadow,
	output logic               shadow_en,
	output logic [3:0]         border,
	output logic               beeper_wr,
	output logic               romrw_en,
	output logic               fntw_en,
	output logic               set_nmi,
	output logic               brk_ena,
	output logic               clr_nmi,
	output logic [15:0]        brk_addr,
	output logic [3:0]         fdd_mask,
	output logic               up_ena,
	output logic [5:0]         up_paladdr,
	output logic [7:0]         up_paldata,
	output logic               up_palwr,
	output logic [7:0]         up_lastwritten
);

	logic [4:0] bd_sub;               // a12..a8
	logic up_wr;
	logic up_a14;
	logic up_select;                  // 1 mode, 0 palette
	zx_io_pkg::ulaplus_word_u up_word;

	assign bd_sub  = bus_wr.ahi[4:0];
	assign up_wr   = bus_wr.wr && bus_wr.sel.ulaplus;
	assign up_a14  = bus_wr.ahi[6];
	assign up_word = bus_wr.din;

	////////////////////////////////////////////////////////////
	// config and control registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
		begin
			border     <= `ZX_RST_BORDER;
			shadow_en  <= 1'b0;
			romrw_en   <= 1'b0;
			fntw_en    <= 1'b0;
			set_nmi    <= 1'b0;
			brk_ena    <= 1'b0;
			brk_addr   <= 16'h0000;
			fdd_mask   <= 4'h0;
			up_ena     <= 1'b0;
			up_select  <= 1'b0;
			up_paladdr <= 6'h00;
		end
		else
		begin
			if (bus_wr.wr && bus_wr.sel.fe_group)
				border <= {!bus_wr.a3, bus_wr.din[2:0]}; // F6 gives bright
			if (bus_wr.wr && bus_wr.sel.bf)
				{brk_ena, set_nmi, fntw_en, romrw_en, shadow_en} <= bus_wr.din[4:0];
			if (bus_wr.wr && bus_wr.sel.bd)
			begin
				if (bd_sub == `ZX_BD_LOBRK)
					brk_addr[7:0] <= bus_wr.din;
				if (bd_sub == `ZX_BD_HIBRK)
					brk_addr[15:8] <= bus_wr.din;
				if (bd_sub == `ZX_BD_FDDMASK)
					fdd_mask <= bus_wr.din[3:0];
			end
			// ULAplus select write
			if (up_wr && !up_a14)
			begin
				if (up_word.sel.grp == 2'b01)
					up_select <= 1'b1;
				else if (up_word.sel.grp == 2'b00)
				begin
					up_select  <= 1'b0;
					up_paladdr <= up_word.sel.addr;
				end
			end
			if (up_wr && up_a14 && up_select)
				up_ena <= bus_wr.din[0]; // mode write
		end

	always_ff @(posedge fclk)
		if (up_wr && up_a14)
			up_lastwritten <= bus_wr.din; // 3B data readback

	assign shadow    = dos || shadow_en;
	assign beeper_wr = bus_wr.wr && bus_wr.sel.fe_only;
	assign clr_nmi   = bus_wr.wr && bus_wr.sel.be;

	// colour data write, G3R3B2 in, R3G3B2 out
	assign up_palwr   = up_wr && up_a14 && !up_select;
	assign up_paldata = {up_word.col.r, up_word.col.g, up_word.col.b};

	a_palwr_single: assert property (@(posedge fclk) disable iff (!rst_n)
		up_palwr |=> !up_palwr);

endmodule

// ==== hw/paging_regs.sv ====
/* 7FFD and EFF7 paging registers with the 1M lock,
   masked outputs and Pentagon-1M page number */

`timescale 1ns/1ns
`include "zx_io_settings.svh"

module paging_regs
(
	input  logic               fclk,
	input  logic               rst_n,
	input  zx_io_pkg::bus_wr_s bus_wr,
	output logic [7:0]         p7ffd,
	output logic [7:0]         peff7,
	output logic [7:0]         p7ffd_raw,
	output logic [7:0]         peff7_raw,
	output logic [5:0]         pent1m_page,
	output logic               pent1m_rom,
	output logic               pent1m_1m_on,
	output logic               pent1m_ram0_0
);

	logic [7:0] p7ffd_q;
	logic [7:0] peff7_q;
	logic block1m;   // EFF7 bit 2, 128k-compatible mode
	logic block7ffd; // 48k lock set while block1m

	assign block1m   = peff7_q[2];
	assign block7ffd = p7ffd_q[5] && block1m;

	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
		begin
			p7ffd_q <= `ZX_RST_P7FFD;
			peff7_q <= `ZX_RST_PEFF7;
		end
		else
		begin
			if (bus_wr.wr && bus_wr.sel.p7ffd && !block7ffd)
				p7ffd_q <= bus_wr.din; // 2..0 page, 3 screen, 4 rom, 5 lock, 7..6 hi page
			if (bus_wr.wr && bus_wr.sel.peff7)
				peff7_q <= bus_wr.din;
		end

	// hide 1M extensions in 128k mode
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_q[7:5]), p7ffd_q[4:0]};
	assign peff7 = block1m ? {peff7_q[7], 1'b0, peff7_q[5:4], 3'b000, peff7_q[0]} : peff7_q;

	assign p7ffd_raw = p7ffd_q; // readback sees the stored bytes
	assign peff7_raw = peff7_q;

	assign pent1m_page   = {p7ffd_q[7:5], p7ffd_q[2:0]};
	assign pent1m_rom    = p7ffd_q[4];
	assign pent1m_1m_on  = !peff7_q[2];
	assign pent1m_ram0_0 = peff7_q[3]; // ram page 0 in rom area

	// the 48k lock holds until an EFF7 write clears block1m
	a_7ffd_locked: assert property (@(posedge fclk) disable iff (!rst_n)
		block7ffd && !(bus_wr.wr && bus_wr.sel.peff7) |=> block7ffd);

endmodule

// ==== hw/port_read_mux.sv ====
/* cpu read data byte: keyboard/tape, BF config,
   BE/BD readback and ULAplus last written value */

`timescale 1ns/1ns
`include "zx_io_settings.svh"

module port_read_mux
(
	input  zx_io_pkg::port_sel_s rd_sel,
	input  logic [15:0]          a,
	input  logic [4:0]           keys_in,
	input  logic                 tape_read,
	input  logic [7:0]           p7ffd_raw,
	input  logic [7:0]           peff7_raw,
	input  logic [3:0]           border,
	input  logic [15:0]          brk_addr,
	input  logic [3:0]           fdd_mask,
	input  logic                 shadow_en,
	input  logic                 romrw_en,
	input  logic                 fntw_en,
	input  logic                 set_nmi,
	input  logic                 brk_ena,
	input  logic [7:0]           up_lastwritten,
	output logic [7:0]           dout
);

	logic [7:0] bd_mux;

	////////////////////////////////////////////////////////////
	// BE/BD readback by a12..a8
	////////////////////////////////////////////////////////////

	always_comb
		case (a[12:8])
			`ZX_BD_P7FFD:    bd_mux = p7ffd_raw;
			`ZX_BD_PEFF7:    bd_mux = peff7_raw;
			`ZX_BD_BORDERRD: bd_mux = {4'h0, border};
			`ZX_BD_LOBRK:    bd_mux = brk_addr[7:0];
			`ZX_BD_HIBRK:    bd_mux = brk_addr[15:8];
			`ZX_BD_FDDMASK:  bd_mux = {4'h0, fdd_mask};
			default:         bd_mux = `ZX_IDLE_READ;
		endcase

	////////////////////////////////////////////////////////////
	// port mux
	////////////////////////////////////////////////////////////

	always_comb
	begin
		if (rd_sel.fe_group)
			dout = {1'b1, tape_read, 1'b0, keys_in}; // keys active low
		else if (rd_sel.bf)
			dout = {3'b000, brk_ena, set_nmi, fntw_en, romrw_en, shadow_en};
		else if (rd_sel.be || rd_sel.bd)
			dout = bd_mux;
		else if (rd_sel.ulaplus)
			dout = up_lastwritten;
		else
			dout = `ZX_IDLE_READ; // paging ports too, write-only
	end

endmodule

// ==== hw/zx_io_pkg.sv ====
/* port select flags, registered write cycle struct
   and the two-view ULAplus data byte */

package zx_io_pkg;

	////////////////////////////////////////////////////////////
	// port hit flags from the low address byte
	////////////////////////////////////////////////////////////

	typedef struct packed
	{
		logic fe_group; // FE, F6 or FC
		logic fe_only;  // FE proper, only with fe_group
		logic p7ffd;    // FD/FC with a15=0
		logic peff7;    // F7, a12=0, a8 swapped by shadow
		logic bf;       // config port
		logic be;       // nmi clear
		logic bd;       // break/fdd/readback
		logic ulaplus;  // 3B
	} port_sel_s;

	////////////////////////////////////////////////////////////
	// one I/O write, captured at the start of the cycle
	////////////////////////////////////////////////////////////

	typedef struct packed
	{
		logic       wr;  // one fclk pulse per bus write
		port_sel_s  sel; // which port got hit
		logic [7:0] ahi; // a15..a8, sub-address and a14
		logic       a3;  // low byte bit 3, border bright bit
		logic [7:0] din; // cpu data
	} bus_wr_s;

	////////////////////////////////////////////////////////////
	// ULAplus data byte
	////////////////////////////////////////////////////////////

	// a14=0: select/address write
	typedef struct packed
	{
		logic [1:0] grp;  // 00 palette, 01 mode
		logic [5:0] addr; // palette entry
	} ulaplus_sel_s;

	// a14=1: colour as the cpu writes it
	typedef struct packed
	{
		logic [2:0] g;
		logic [2:0] r;
		logic [1:0] b;
	} ulaplus_col_s;

	typedef union packed
	{
		logic [7:0]   raw;
		ulaplus_sel_s sel;
		ulaplus_col_s col;
	} ulaplus_word_u;

endpackage

// ==== hw/zx_io_settings.svh ====
/* port numbers, BD sub-addresses, idle read value
   and register reset values for the I/O port block */

`ifndef ZX_IO_SETTINGS_SVH
`define ZX_IO_SETTINGS_SVH

// low address byte of each port
`define ZX_PORT_FE      8'hFE // border, beeper, keyboard
`define ZX_PORT_F6      8'hF6 // border alias
`define ZX_PORT_FC      8'hFC // border and 7FFD alias
`define ZX_PORT_FD      8'hFD // 7FFD paging
`define ZX_PORT_F7      8'hF7 // EFF7
`define ZX_PORT_BF      8'hBF // config
`define ZX_PORT_BE      8'hBE // nmi clear, readback
`define ZX_PORT_BD      8'hBD // break addr, fdd mask, readback
`define ZX_PORT_ULAPLUS 8'h3B

// BD/BE sub-addresses on a12..a8
`define ZX_BD_P7FFD     5'h0A
`define ZX_BD_PEFF7     5'h0B
`define ZX_BD_BORDERRD  5'h0F
`define ZX_BD_LOBRK     5'h10
`define ZX_BD_HIBRK     5'h11
`define ZX_BD_FDDMASK   5'h13

`define ZX_IDLE_READ    8'hFF // floating bus on unmatched port

`define ZX_RST_P7FFD    8'h00
`define ZX_RST_PEFF7    8'h00
`define ZX_RST_BORDER   4'h0

`endif

// ==== hw/zx_io_top.sv ====
/* I/O port block top: decoder, paging and config
   registers, read mux */

`timescale 1ns/1ns

module zx_io_top
(
	input  logic        fclk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        dos,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic [5:0]  pent1m_page,
	output logic        pent1m_rom,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0,
	output logic [3:0]  border,
	output logic        beeper_wr,
	output logic        romrw_en,
	output logic        fntw_en,
	output logic        set_nmi,
	output logic        brk_ena,
	output logic        clr_nmi,
	output logic [15:0] brk_addr,
	output logic [3:0]  fdd_mask,
	output logic        up_ena,
	output logic [5:0]  up_paladdr,
	output logic [7:0]  up_paldata,
	output logic        up_palwr
);

	zx_io_pkg::bus_wr_s   bus_wr;
	zx_io_pkg::port_sel_s rd_sel;
	logic shadow;              // back into the decoder for EFF7
	logic shadow_en;
	logic [7:0] p7ffd_raw;
	logic [7:0] peff7_raw;
	logic [7:0] up_lastwritten;

	io_cycle_decode i_decode
	(
		.fclk(fclk), .rst_n(rst_n), .a(a), .din(din),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .shadow(shadow),
		.bus_wr(bus_wr), .rd_sel(rd_sel), .porthit(porthit), .dataout_en(dataout)
	);

	paging_regs i_paging
	(
		.fclk(fclk), .rst_n(rst_n), .bus_wr(bus_wr),
		.p7ffd(p7ffd), .peff7(peff7), .p7ffd_raw(p7ffd_raw), .peff7_raw(peff7_raw),
		.pent1m_page(pent1m_page), .pent1m_rom(pent1m_rom),
		.pent1m_1m_on(pent1m_1m_on), .pent1m_ram0_0(pent1m_ram0_0)
	);

	machine_cfg_regs i_cfg
	(
		.fclk(fclk), .rst_n(rst_n), .bus_wr(bus_wr), .dos(dos),
		.shadow(shadow), .shadow_en(shadow_en), .border(border), .beeper_wr(beeper_wr),
		.romrw_en(romrw_en), .fntw_en(fntw_en), .set_nmi(set_nmi), .brk_ena(brk_ena),
		.clr_nmi(clr_nmi), .brk_addr(brk_addr), .fdd_mask(fdd_mask),
		.up_ena(up_ena), .up_paladdr(up_paladdr), .up_paldata(up_paldata),
		.up_palwr(up_palwr), .up_lastwritten(up_lastwritten)
	);

	port_read_mux i_rdmux
	(
		.rd_sel(rd_sel), .a(a), .keys_in(keys_in), .tape_read(tape_read),
		.p7ffd_raw(p7ffd_raw), .peff7_raw(peff7_raw), .border(border),
		.brk_addr(brk_addr), .fdd_mask(fdd_mask), .shadow_en(shadow_en),
		.romrw_en(romrw_en), .fntw_en(fntw_en), .set_nmi(set_nmi), .brk_ena(brk_ena),
		.up_lastwritten(up_lastwritten), .dout(dout)
	);

endmodule

// ==== verif/tb_zx_io.sv ====
/* testbench for the I/O port block: lcg, reference model,
   bus write/read tasks, pulse monitor and compare process */

`timescale 1ns/1ns
`include "zx_io_settings.svh"

module tb_zx_io;

	logic fclk;
	logic rst_n;
	logic [15:0] a;
	logic [7:0] din;
	logic iorq_n, rd_n, wr_n;
	logic dos;
	logic [4:0] keys_in;
	logic tape_read;
	logic [7:0] dout, p7ffd, peff7, up_paldata;
	logic dataout, porthit;
	logic [5:0] pent1m_page, up_paladdr;
	logic pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	logic [3:0] border, fdd_mask;
	logic romrw_en, fntw_en, set_nmi, brk_ena, up_ena;
	logic beeper_wr, clr_nmi, up_palwr; // one-cycle pulses
	logic [15:0] brk_addr;

	// reference register state
	logic [7:0] m_p7ffd, m_peff7, m_last;
	logic [3:0] m_border, m_fdd;
	logic [4:0] m_cfg;        // brk_ena..shadow_en
	logic [15:0] m_brk;
	logic m_ena, m_sel;       // m_sel 1 = mode, 0 = palette
	logic [5:0] m_paladdr;

	logic [31:0] lcg_state;
	string cur_test;
	string chk_name[$];       // pending checks for the compare process
	logic [15:0] chk_exp[$];
	logic [15:0] chk_act[$];
	int n_checks, n_errors, test_errors;
	int n_beep, n_clr, n_palwr;
	logic [7:0] palwr_data;   // up_paldata seen with the palwr pulse
	logic [7:0] port_tab [8];
	logic [7:0] d, prev;
	logic [15:0] adr;

	zx_io_top i_zx_io_top (.*);

	initial
	begin
		fclk = 1'b0;
		forever #2 fclk = !fclk;
	end

	function automatic logic [7:0] rand8();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16]; // low bits have short cycles
	endfunction

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	function automatic logic expected_hit(input logic [15:0] ad);
		logic [7:0] lo;
		logic sh;
		lo = ad[7:0];
		sh = dos || m_cfg[0];
		return lo == `ZX_PORT_FE || lo == `ZX_PORT_F6 || lo == `ZX_PORT_FC
			|| ((lo == `ZX_PORT_FD || lo == `ZX_PORT_FC) && !ad[15])
			|| (lo == `ZX_PORT_F7 && !ad[12] && ad[8] == !sh) // eff7 moves with shadow
			|| lo == `ZX_PORT_BF || lo == `ZX_PORT_BE || lo == `ZX_PORT_BD
			|| lo == `ZX_PORT_ULAPLUS;
	endfunction

	function automatic logic [7:0] expected_read(input logic [15:0] ad);
		logic [7:0] lo;
		lo = ad[7:0];
		if (lo == `ZX_PORT_FE || lo == `ZX_PORT_F6 || lo == `ZX_PORT_FC)
			return {1'b1, tape_read, 1'b0, keys_in};
		if (lo == `ZX_PORT_BF)
			return {3'b000, m_cfg};
		if (lo == `ZX_PORT_BE || lo == `ZX_PORT_BD)
			case (ad[12:8])
				5'h0A: return m_p7ffd; // raw value
				5'h0B: return m_peff7;
				5'h0F: return {4'h0, m_border};
				5'h10: return m_brk[7:0];
				5'h11: return m_brk[15:8];
				5'h13: return {4'h0, m_fdd};
				default: return 8'hFF;
			endcase
		if (lo == `ZX_PORT_ULAPLUS)
			return m_last;
		return 8'hFF;
	endfunction

	function automatic void model_write(input logic [15:0] ad, input logic [7:0] data);
		logic [7:0] lo;
		logic locked;
		lo = ad[7:0];
		locked = m_p7ffd[5] && m_peff7[2]; // 48k lock under block1m
		if (lo == `ZX_PORT_FE || lo == `ZX_PORT_F6 || lo == `ZX_PORT_FC)
			m_border = {!ad[3], data[2:0]};
		if ((lo == `ZX_PORT_FD || lo == `ZX_PORT_FC) && !ad[15] && !locked)
			m_p7ffd = data;
		if (lo == `ZX_PORT_F7 && !ad[12] && ad[8] && !(dos || m_cfg[0]))
			m_peff7 = data;
		if (lo == `ZX_PORT_BF)
			m_cfg = data[4:0];
		if (lo == `ZX_PORT_BD && ad[12:8] == 5'h10)
			m_brk[7:0] = data;
		if (lo == `ZX_PORT_BD && ad[12:8] == 5'h11)
			m_brk[15:8] = data;
		if (lo == `ZX_PORT_BD && ad[12:8] == 5'h13)
			m_fdd = data[3:0];
		if (lo == `ZX_PORT_ULAPLUS && !ad[14] && data[7:6] == 2'b01)
			m_sel = 1'b1;
		if (lo == `ZX_PORT_ULAPLUS && !ad[14] && data[7:6] == 2'b00)
		begin
			m_sel = 1'b0;
			m_paladdr = data[5:0];
		end
		if (lo == `ZX_PORT_ULAPLUS && ad[14])
		begin
			m_last = data;
			if (m_sel)
				m_ena = data[0];
		end
	endfunction

	////////////////////////////////////////////////////////////
	// bus tasks and checking
	////////////////////////////////////////////////////////////

	task automatic expect_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
		chk_name.push_back({cur_test, " ", name});
		chk_exp.push_back(exp);
		chk_act.push_back(act);
	endtask

	task automatic bus_write(input logic [15:0] ad, input logic [7:0] data);
		@(posedge fclk);
		a <= ad;
		din <= data;
		iorq_n <= 1'b0;
		wr_n <= 1'b0;
		repeat (3) @(posedge fclk); // strobe low 3 cycles
		iorq_n <= 1'b1;
		wr_n <= 1'b1;
		repeat (2) @(posedge fclk);
		model_write(ad, data);
	endtask

	// read and compare dout, porthit and dataout with the model
	task automatic check_read(input logic [15:0] ad);
		logic [7:0] rnd;
		rnd = rand8();
		@(posedge fclk);
		a <= ad;
		keys_in <= rnd[4:0];
		tape_read <= rnd[7];
		iorq_n <= 1'b0;
		rd_n <= 1'b0;
		@(posedge fclk);
		@(negedge fclk); // mid-cycle sample
		expect_eq($sformatf("dout %h", ad), 16'(expected_read(ad)), 16'(dout));
		expect_eq($sformatf("porthit %h", ad), 16'(expected_hit(ad)), 16'(porthit));
		expect_eq($sformatf("dataout %h", ad), 16'(expected_hit(ad)), 16'(dataout));
		@(posedge fclk);
		iorq_n <= 1'b1;
		rd_n <= 1'b1;
	endtask

	task automatic end_test(input string name);
		int guard;
		guard = 0;
		while (chk_name.size() > 0 && guard < 100)
		begin
			@(posedge fclk);
			guard++;
		end
		if (chk_name.size() > 0)
		begin
			$display("timeout: compare queue of test %s did not drain", name);
			n_errors++;
			test_errors++;
		end
		$display("test %s done, %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	// compare process
	always @(negedge fclk)
	begin : compare_proc
		string nm;
		logic [15:0] ev;
		logic [15:0] av;
		while (chk_name.size() > 0)
		begin
			nm = chk_name.pop_front();
			ev = chk_exp.pop_front();
			av = chk_act.pop_front();
			n_checks++;
			if (av !== ev)
			begin
				$display("Error %s: expected %h, actual %h", nm, ev, av);
				n_errors++;
				test_errors++;
			end
		end
	end

	// pulse counters
	always @(negedge fclk)
	begin
		if (beeper_wr)
			n_beep++;
		if (clr_nmi)
			n_clr++;
		if (up_palwr)
		begin
			n_palwr++;
			palwr_data = up_paldata;
		end
	end

	initial
	begin
		rst_n = 1'b0;
		a = 16'h0000;
		din = 8'h00;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		dos = 1'b0;
		keys_in = 5'h1F;
		tape_read = 1'b0;
		lcg_state = 32'd21;
		{m_p7ffd, m_peff7, m_border, m_fdd, m_cfg, m_brk} = '0;
		{m_ena, m_sel, m_paladdr} = '0;
		m_last = 8'hxx; // 3B readback has no reset
		n_checks = 0;
		n_errors = 0;
		test_errors = 0;
		port_tab = '{`ZX_PORT_FE, `ZX_PORT_F6, `ZX_PORT_FC, `ZX_PORT_FD,
			`ZX_PORT_F7, `ZX_PORT_BF, `ZX_PORT_BD, `ZX_PORT_ULAPLUS};
		repeat (4) @(posedge fclk);
		rst_n <= 1'b1;

		////////////////////////////////////////////////////////////
		// border, beeper, keyboard
		////////////////////////////////////////////////////////////
		cur_test = "border";
		expect_eq("reset paging", 16'h0000, {p7ffd, peff7});
		expect_eq("reset cfg", 16'h0000, 16'({border, fdd_mask, up_ena, up_paladdr}));
		expect_eq("reset brk", 16'h0000, brk_addr);
		n_beep = 0;
		bus_write(16'h00FE, rand8());
		expect_eq("border FE", 16'(m_border), 16'(border));
		expect_eq("beeper FE", 16'd1, 16'(n_beep));
		bus_write(16'h00F6, rand8()); // a3=0 gives bright
		expect_eq("border F6", 16'(m_border), 16'(border));
		n_beep = 0;
		bus_write(16'h80FC, rand8());
		expect_eq("border FC", 16'(m_border), 16'(border));
		expect_eq("beeper FC", 16'd0, 16'(n_beep));
		check_read(16'h00FE);
		end_test(cur_test);

		////////////////////////////////////////////////////////////
		// paging and the 1M lock
		////////////////////////////////////////////////////////////
		cur_test = "paging";
		bus_write(16'h7FFD, rand8() & 8'hDF);
		bus_write(16'hEFF7, rand8() & 8'hFB);
		expect_eq("p7ffd", 16'(m_p7ffd), 16'(p7ffd));
		expect_eq("peff7", 16'(m_peff7), 16'(peff7));
		expect_eq("page", 16'({m_p7ffd[7:5], m_p7ffd[2:0]}), 16'(pent1m_page));
		expect_eq("pent1m bits", 16'({m_p7ffd[4], !m_peff7[2], m_peff7[3]}),
			16'({pent1m_rom, pent1m_1m_on, pent1m_ram0_0}));
		bus_write(16'hEFF7, rand8() | 8'h04); // block1m
		bus_write(16'h7FFD, rand8() | 8'h20); // lock
		prev = m_p7ffd;
		bus_write(16'h7FFD, rand8());
		expect_eq("p7ffd locked", 16'({prev[7:5], prev[2:0]}), 16'(pent1m_page));
		expect_eq("p7ffd masked", 16'(m_p7ffd & 8'h1F), 16'(p7ffd));
		expect_eq("peff7 masked", 16'(m_peff7 & 8'hB1), 16'(peff7));
		expect_eq("pent1m bits 1m", 16'({m_p7ffd[4], !m_peff7[2], m_peff7[3]}),
			16'({pent1m_rom, pent1m_1m_on, pent1m_ram0_0}));
		end_test(cur_test);

		////////////////////////////////////////////////////////////
		// config port and shadow
		////////////////////////////////////////////////////////////
		cur_test = "config";
		bus_write(16'h00BF, rand8());
		expect_eq("cfg outputs", 16'(m_cfg[4:1]), 16'({brk_ena, set_nmi, fntw_en, romrw_en}));
		check_read(16'h00BF);
		bus_write(16'h00BF, 8'h00);
		bus_write(16'hEFF7, rand8() & 8'hFB);
		@(posedge fclk);
		dos <= 1'b1;
		prev = m_peff7;
		bus_write(16'hEFF7, rand8());
		expect_eq("eff7 dos", 16'(prev), 16'(peff7));
		check_read(16'hEEF7); // a8=0 hits in shadow
		@(posedge fclk);
		dos <= 1'b0;
		bus_write(16'h00BF, 8'h01); // shadow enable
		bus_write(16'hEFF7, rand8());
		expect_eq("eff7 shadow", 16'(prev), 16'(peff7));
		bus_write(16'hEEF7, rand8()); // shadow address is read-only
		expect_eq("eff7 shadow a8=0", 16'(prev), 16'(peff7));
		bus_write(16'h00BF, 8'h00);
		bus_write(16'hEFF7, rand8() & 8'hFB);
		expect_eq("eff7 normal", 16'(m_peff7), 16'(peff7));
		end_test(cur_test);

		////////////////////////////////////////////////////////////
		// BD/BE ports
		////////////////////////////////////////////////////////////
		cur_test = "bd";
		bus_write(16'h10BD, rand8());
		bus_write(16'h11BD, rand8());
		bus_write(16'h13BD, rand8());
		expect_eq("brk_addr", m_brk, brk_addr);
		expect_eq("fdd_mask", 16'(m_fdd), 16'(fdd_mask));
		foreach (port_tab[i])
			if (i < 6)
				check_read({3'b000, 5'h0A + 5'(i), `ZX_PORT_BD}); // 0A..0F
		check_read(16'h10BD);
		check_read(16'h11BD);
		check_read(16'h13BE);
		n_clr = 0;
		bus_write(16'h00BE, rand8());
		expect_eq("clr_nmi", 16'd1, 16'(n_clr));
		end_test(cur_test);

		////////////////////////////////////////////////////////////
		// ULAplus
		////////////////////////////////////////////////////////////
		cur_test = "ulaplus";
		bus_write(16'hBF3B, rand8() & 8'h3F); // palette group at a14=0
		expect_eq("paladdr", 16'(m_paladdr), 16'(up_paladdr));
		d = rand8();
		n_palwr = 0;
		bus_write(16'hFF3B, d);
		expect_eq("palwr", 16'd1, 16'(n_palwr));
		expect_eq("paldata", 16'({d[4:2], d[7:5], d[1:0]}), 16'(palwr_data));
		check_read(16'hFF3B);
		bus_write(16'hBF3B, 8'h40); // mode group
		n_palwr = 0;
		bus_write(16'hFF3B, 8'h01);
		expect_eq("up_ena", 16'(m_ena), 16'(up_ena));
		expect_eq("palwr mode", 16'd0, 16'(n_palwr));
		end_test(cur_test);

		////////////////////////////////////////////////////////////
		// random reads
		////////////////////////////////////////////////////////////
		cur_test = "random";
		for (int i = 0; i < 200; i++)
		begin
			adr = {rand8(), rand8()};
			d = rand8();
			if (d[0])
				adr[7:0] = port_tab[d[3:1]]; // half the reads on real ports
			check_read(adr);
		end
		end_test(cur_test);

		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
